/* include/axi_dc_defs.svh */
// Dual-clock write slave widths
`ifndef AXI_DC_DEFS_SVH
`define AXI_DC_DEFS_SVH

// AXI address bus width
`define AXI_DC_ADDR_WIDTH 32

// AXI data bus width, strobe is one bit per byte of this
`define AXI_DC_DATA_WIDTH 64

// Transaction ID width, shared by AW and B
`define AXI_DC_ID_WIDTH 6

// Slots per token ring
// One slot always stays empty, so a ring holds depth minus one beats
`define AXI_DC_RING_DEPTH 8

`endif

/* verilog/axi_dc_pkg.sv */
// Dual-clock write slave types
package axi_dc_pkg;

    `include "axi_dc_defs.svh"

    typedef logic [`AXI_DC_ADDR_WIDTH-1:0]   axi_addr_t;
    typedef logic [`AXI_DC_DATA_WIDTH-1:0]   axi_data_t;
    typedef logic [`AXI_DC_DATA_WIDTH/8-1:0] axi_strb_t;
    typedef logic [`AXI_DC_ID_WIDTH-1:0]     axi_id_t;
    typedef logic [7:0]                      axi_len_t;
    typedef logic [2:0]                      axi_size_t;
    typedef logic [1:0]                      axi_burst_t;
    typedef logic [1:0]                      axi_resp_t;

    // One-hot slot select, one bit per ring slot
    typedef logic [`AXI_DC_RING_DEPTH-1:0]   ring_ptr_t;

    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } aw_beat_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } w_beat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } b_beat_t;

endpackage

/* verilog/dc_token_ring_din.sv */
// Token ring buffer, local write side
`timescale 1ns/1ps

module dc_token_ring_din
    import axi_dc_pkg::*;
#(
    parameter type payload_t = aw_beat_t
) (
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      valid_i,
    output logic      ready_o,
    input  payload_t  data_i,

    output ring_ptr_t write_token_o,
    input  ring_ptr_t read_pointer_i,
    output payload_t  data_async_o
);

    localparam int DEPTH = $bits(ring_ptr_t);

    payload_t  slot_q [DEPTH];
    ring_ptr_t token_next;
    ring_ptr_t rp_meta_q;
    ring_ptr_t rp_sync_q;
    logic      ptr_valid;
    logic      full;
    logic      transfer;

    assign token_next = {write_token_o[DEPTH-2:0], write_token_o[DEPTH-1]};

    // Synchronizer flops start at zero, which no remote pointer ever is
    assign ptr_valid = |rp_sync_q;

    // Keep one slot free so that token and pointer never coincide
    assign full     = (token_next == rp_sync_q);
    assign ready_o  = ptr_valid && !full;
    assign transfer = valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            write_token_o <= ring_ptr_t'(1);
        end else if (transfer) begin
            write_token_o <= token_next;
        end
    end

    // Two-flop synchronizer for the remote read pointer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rp_meta_q <= '0;
            rp_sync_q <= '0;
        end else begin
            rp_meta_q <= read_pointer_i;
            rp_sync_q <= rp_meta_q;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (transfer && write_token_o[i]) begin
                slot_q[i] <= data_i;
            end
        end
    end

    // Remote side reads through a one-hot mux
    always_comb begin
        data_async_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (read_pointer_i[i]) begin
                data_async_o = slot_q[i];
            end
        end
    end

    token_onehot_a: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot(write_token_o)
    );

    // Even the live remote pointer must never see a write fill the last free slot
    no_write_full_a: assert property (
        @(posedge clk_i) disable iff (rst_i) transfer |-> token_next != read_pointer_i
    );

endmodule

/* verilog/dc_token_ring_dout.sv */
// Token ring buffer, local read side
`timescale 1ns/1ps

module dc_token_ring_dout
    import axi_dc_pkg::*;
#(
    parameter type payload_t = b_beat_t
) (
    input  logic      clk_i,
    input  logic      rst_i,

    output logic      valid_o,
    input  logic      ready_i,
    output payload_t  data_o,

    input  ring_ptr_t write_token_i,
    output ring_ptr_t read_pointer_o,
    input  payload_t  data_async_i
);

    localparam int DEPTH = $bits(ring_ptr_t);

    ring_ptr_t wt_meta_q;
    ring_ptr_t wt_sync_q;
    ring_ptr_t pointer_next;
    logic      transfer;

    // Start in step with the remote token, so the ring reads empty
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wt_meta_q <= ring_ptr_t'(1);
            wt_sync_q <= ring_ptr_t'(1);
        end else begin
            wt_meta_q <= write_token_i;
            wt_sync_q <= wt_meta_q;
        end
    end

    assign valid_o  = (read_pointer_o != wt_sync_q);
    assign transfer = valid_o && ready_i;

    assign pointer_next = {read_pointer_o[DEPTH-2:0], read_pointer_o[DEPTH-1]};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            read_pointer_o <= ring_ptr_t'(1);
        end else if (transfer) begin
            read_pointer_o <= pointer_next;
        end
    end

    // Remote side muxes the slot under read_pointer_o
    assign data_o = data_async_i;

    pointer_onehot_a: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot(read_pointer_o)
    );

endmodule

/* verilog/axi_reg_slice.sv */
// Single-entry valid/ready slice
`timescale 1ns/1ps

module axi_reg_slice
    import axi_dc_pkg::*;
#(
    parameter type payload_t = b_beat_t
) (
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    payload_t data_q;
    logic     valid_q;

    // Free when empty or when the held beat leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    hold_stable_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    );

endmodule

/* verilog/axi_dc_write_slave.sv */
// Dual-clock AXI write slave bridge
`timescale 1ns/1ps

module axi_dc_write_slave
    import axi_dc_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Local AXI slave port
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  aw_beat_t  aw_i,
    input  logic      w_valid_i,
    output logic      w_ready_o,
    input  w_beat_t   w_i,
    output logic      b_valid_o,
    input  logic      b_ready_i,
    output b_beat_t   b_o,

    // Remote clock domain
    output ring_ptr_t aw_write_token_o,
    input  ring_ptr_t aw_read_pointer_i,
    output aw_beat_t  aw_async_o,
    output ring_ptr_t w_write_token_o,
    input  ring_ptr_t w_read_pointer_i,
    output w_beat_t   w_async_o,
    input  ring_ptr_t b_write_token_i,
    output ring_ptr_t b_read_pointer_o,
    input  b_beat_t   b_async_i
);

    logic    b_dc_valid;
    logic    b_dc_ready;
    b_beat_t b_dc;

    dc_token_ring_din #(.payload_t(aw_beat_t)) u_aw_ring (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (aw_valid_i),
        .ready_o        (aw_ready_o),
        .data_i         (aw_i),
        .write_token_o  (aw_write_token_o),
        .read_pointer_i (aw_read_pointer_i),
        .data_async_o   (aw_async_o)
    );

    dc_token_ring_din #(.payload_t(w_beat_t)) u_w_ring (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (w_valid_i),
        .ready_o        (w_ready_o),
        .data_i         (w_i),
        .write_token_o  (w_write_token_o),
        .read_pointer_i (w_read_pointer_i),
        .data_async_o   (w_async_o)
    );

    dc_token_ring_dout #(.payload_t(b_beat_t)) u_b_ring (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_o        (b_dc_valid),
        .ready_i        (b_dc_ready),
        .data_o         (b_dc),
        .write_token_i  (b_write_token_i),
        .read_pointer_o (b_read_pointer_o),
        .data_async_i   (b_async_i)
    );

    // Registers B so the remote slot mux does not reach the local port
    axi_reg_slice #(.payload_t(b_beat_t)) u_b_slice (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (b_dc_valid),
        .ready_o (b_dc_ready),
        .data_i  (b_dc),
        .valid_o (b_valid_o),
        .ready_i (b_ready_i),
        .data_o  (b_o)
    );

endmodule

/* dv/tb_axi_dc_write_slave.sv */
// Dual-clock write slave testbench
`timescale 1ns/1ps
`include "axi_dc_defs.svh"

module tb_axi_dc_write_slave
    import axi_dc_pkg::*;
();

    localparam int DEPTH   = `AXI_DC_RING_DEPTH;
    localparam int N       = 6;
    localparam int TIMEOUT = 200;

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
    aw_beat_t  aw_i, aw_async_o;
    w_beat_t   w_i, w_async_o;
    b_beat_t   b_o, b_async_i;
    ring_ptr_t aw_write_token_o, aw_read_pointer_i;
    ring_ptr_t w_write_token_o, w_read_pointer_i;
    ring_ptr_t b_write_token_i, b_read_pointer_o;

    aw_beat_t aw_tab [N];
    w_beat_t  w_tab [N];
    b_beat_t  b_tab [N];
    b_beat_t  b_slot [DEPTH];

    int checks = 0;
    int mismatches = 0;
    int timeouts = 0;

    always #2 clk_i = ~clk_i;

    axi_dc_write_slave u_dut (.*);

    // Remote B ring muxed by the bridge's read pointer
    always_comb begin
        b_async_i = '0;
        for (int s = 0; s < DEPTH; s++) begin
            if (b_read_pointer_o[s])
                b_async_i = b_slot[s];
        end
    end

    function automatic ring_ptr_t rotate_slot(input ring_ptr_t p);
        return {p[DEPTH-2:0], p[DEPTH-1]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic load_tables();
        aw_tab[0] = '{id: 6'h01, addr: 32'h0000_1000, len: 8'd0, size: 3'd3, burst: 2'b01};
        aw_tab[1] = '{id: 6'h2a, addr: 32'h8000_0040, len: 8'd3, size: 3'd3, burst: 2'b01};
        aw_tab[2] = '{id: 6'h3f, addr: 32'hdead_beec, len: 8'd15, size: 3'd2, burst: 2'b10};
        aw_tab[3] = '{id: 6'h10, addr: 32'h0000_0000, len: 8'd255, size: 3'd0, burst: 2'b00};
        aw_tab[4] = '{id: 6'h05, addr: 32'h7fff_fff8, len: 8'd1, size: 3'd3, burst: 2'b01};
        aw_tab[5] = '{id: 6'h22, addr: 32'h1234_5678, len: 8'd7, size: 3'd1, burst: 2'b10};
        w_tab[0] = '{data: 64'h0123_4567_89ab_cdef, strb: 8'hff, last: 1'b1};
        w_tab[1] = '{data: 64'hffff_0000_ffff_0000, strb: 8'h0f, last: 1'b0};
        w_tab[2] = '{data: 64'h0000_0000_0000_0001, strb: 8'h01, last: 1'b0};
        w_tab[3] = '{data: 64'hdead_beef_cafe_f00d, strb: 8'hf0, last: 1'b1};
        w_tab[4] = '{data: 64'h8000_0000_0000_0000, strb: 8'h80, last: 1'b0};
        w_tab[5] = '{data: 64'h5a5a_a5a5_3c3c_c3c3, strb: 8'h3c, last: 1'b1};
        b_tab[0] = '{id: 6'h01, resp: 2'b00};
        b_tab[1] = '{id: 6'h2a, resp: 2'b01};
        b_tab[2] = '{id: 6'h3f, resp: 2'b10};
        b_tab[3] = '{id: 6'h10, resp: 2'b11};
        b_tab[4] = '{id: 6'h05, resp: 2'b00};
        b_tab[5] = '{id: 6'h22, resp: 2'b10};
    endtask

    // Local AW/W writer and remote reader with one loop pass per cycle
    task automatic stream_aw_w();
        int   sent_aw = 0;
        int   sent_w = 0;
        int   got_aw = 0;
        int   got_w = 0;
        int   cycles = 0;
        logic take_aw;
        logic take_w;
        while ((got_aw < N || got_w < N) && cycles < TIMEOUT) begin
            aw_valid_i = (sent_aw < N);
            w_valid_i  = (sent_w < N);
            aw_i = aw_tab[sent_aw % N];
            w_i  = w_tab[sent_w % N];
            @(negedge clk_i);
            // A slot is written once the token has moved past the pointer
            take_aw = (got_aw < N) && (aw_write_token_o != aw_read_pointer_i)
                      && ($urandom % 2 == 0);
            take_w  = (got_w < N) && (w_write_token_o != w_read_pointer_i)
                      && ($urandom % 2 == 0);
            if (take_aw)
                check_value("aw_async_o", 128'(aw_async_o), 128'(aw_tab[got_aw]));
            if (take_w)
                check_value("w_async_o", 128'(w_async_o), 128'(w_tab[got_w]));
            if (aw_valid_i && aw_ready_o)
                sent_aw++;
            if (w_valid_i && w_ready_o)
                sent_w++;
            @(posedge clk_i);
            #1;
            if (take_aw) begin
                aw_read_pointer_i = rotate_slot(aw_read_pointer_i);
                got_aw++;
            end
            if (take_w) begin
                w_read_pointer_i = rotate_slot(w_read_pointer_i);
                got_w++;
            end
            cycles++;
        end
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        if (got_aw < N || got_w < N)
            report_timeout("AW and W beats did not all reach the remote side");
    endtask

    task automatic count_aw_accepts(input int window, output int accepted);
        accepted = 0;
        for (int c = 0; c < window; c++) begin
            aw_valid_i = 1'b1;
            aw_i = aw_tab[c % N];
            @(negedge clk_i);
            if (aw_ready_o)
                accepted++;
            @(posedge clk_i);
            #1;
        end
        aw_valid_i = 1'b0;
    endtask

    // Remote B writer and local collector with random ready stalls
    task automatic stream_b();
        int put = 0;
        int got = 0;
        int cycles = 0;
        while (got < N && cycles < TIMEOUT) begin
            b_ready_i = ($urandom % 4 != 0);
            if (put < N && rotate_slot(b_write_token_i) != b_read_pointer_o) begin
                b_slot[put % DEPTH] = b_tab[put];
                b_write_token_i = rotate_slot(b_write_token_i);
                put++;
            end
            @(negedge clk_i);
            if (b_valid_o && b_ready_i) begin
                check_value("b_o", 128'(b_o), 128'(b_tab[got]));
                got++;
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (got < N)
            report_timeout("B beats did not all leave on b_o");
    endtask

    initial begin
        int cycles;
        int accepted;
        void'($urandom(18));
        load_tables();
        rst_i = 1'b1;
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        b_ready_i  = 1'b0;
        aw_i = '0;
        w_i  = '0;
        aw_read_pointer_i = ring_ptr_t'(1);
        w_read_pointer_i  = ring_ptr_t'(1);
        b_write_token_i   = ring_ptr_t'(1);
        for (int s = 0; s < DEPTH; s++)
            b_slot[s] = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        @(negedge clk_i);
        check_value("b_valid_o", 128'(b_valid_o), 128'(0));
        check_value("aw_write_token_o", 128'(aw_write_token_o), 128'(1));
        check_value("w_write_token_o", 128'(w_write_token_o), 128'(1));
        check_value("b_read_pointer_o", 128'(b_read_pointer_o), 128'(1));
        cycles = 0;
        while (!(aw_ready_o && w_ready_o) && cycles < 5) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!(aw_ready_o && w_ready_o))
            report_timeout("aw_ready_o and w_ready_o did not rise within 5 cycles");
        @(posedge clk_i);
        #1;
        stream_aw_w();

        // Remote AW pointer held still
        count_aw_accepts(20, accepted);
        check_value("aw accepted count", 128'(accepted), 128'(DEPTH - 1));
        check_value("aw_ready_o", 128'(aw_ready_o), 128'(0));
        aw_read_pointer_i = rotate_slot(aw_read_pointer_i);
        count_aw_accepts(12, accepted);
        check_value("aw accepted count", 128'(accepted), 128'(1));

        stream_b();
        // Nothing left over once every B beat is out
        b_ready_i = 1'b1;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk_i);
            check_value("b_valid_o", 128'(b_valid_o), 128'(0));
        end
        // Bridge has freed every slot the remote side wrote
        check_value("b_read_pointer_o", 128'(b_read_pointer_o), 128'(b_write_token_i));

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* axi_dc_write_slave.f */
+incdir+include
verilog/axi_dc_pkg.sv
verilog/dc_token_ring_din.sv
verilog/dc_token_ring_dout.sv
verilog/axi_reg_slice.sv
verilog/axi_dc_write_slave.sv
dv/tb_axi_dc_write_slave.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f axi_dc_write_slave.f \
    --top-module tb_axi_dc_write_slave > sim.log 2>&1 \
    && ./obj_dir/Vtb_axi_dc_write_slave >> sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
